//--- filelist.f
rtl/alu_pkg.sv
rtl/alu_add.sv
rtl/alu_shift.sv
rtl/alu_cmp.sv
rtl/alu_logic.sv
rtl/alu.sv
rtl/exe_alu_stage.sv
test/alu_checker.sv
test/tb_exe_alu_stage.sv

//--- rtl/alu.sv
// Combinational integer ALU, zero cycles from instruction_i to instruction_o
// Output valid only for valid UNIT_ALU or UNIT_SYSTEM instructions
// Unknown types return rs1 on UNIT_SYSTEM and zero otherwise
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  alu_pkg::rr_exe_arith_instr_t  instruction_i,
    output alu_pkg::exe_wb_scalar_instr_t instruction_o
);
    import alu_pkg::*;

    instr_type_t instr_type;
    bus64_t      data_rs1;
    bus64_t      data_rs2;
    bus64_t      data_rs1_extended;
    bus64_t      data_rs1_shifted;
    bus64_t      add_result;
    bus64_t      shift_result;
    bus64_t      cmp_result;
    bus64_t      logic_result;
    bus64_t      result_modules;
    bus64_t      result;
    logic [3:0]  sel;

    assign instr_type = instruction_i.instr_type;
    assign data_rs1   = instruction_i.data_rs1;
    assign data_rs2   = instruction_i.data_rs2;

    // ----------------------------------------
    // Operand preparation
    // ----------------------------------------
    always_comb begin
        case (instr_type)
            ADDUW, SH1ADDUW, SH2ADDUW, SH3ADDUW, ZEXTW, SLLIUW, SLLW, SRLW, RORW, ROLW: begin
                data_rs1_extended = {32'b0, data_rs1[31:0]};
            end
            ZEXTH:   data_rs1_extended = {48'b0, data_rs1[15:0]};
            SRAW:    data_rs1_extended = {{32{data_rs1[31]}}, data_rs1[31:0]};
            SEXTH:   data_rs1_extended = {{48{data_rs1[15]}}, data_rs1[15:0]};
            SEXTB:   data_rs1_extended = {{56{data_rs1[7]}}, data_rs1[7:0]};
            default: data_rs1_extended = data_rs1;
        endcase
    end

    // Pre-shift for the shift-add group
    always_comb begin
        case (instr_type)
            SH1ADD, SH1ADDUW: data_rs1_shifted = data_rs1_extended << 1;
            SH2ADD, SH2ADDUW: data_rs1_shifted = data_rs1_extended << 2;
            SH3ADD, SH3ADDUW: data_rs1_shifted = data_rs1_extended << 3;
            default:          data_rs1_shifted = data_rs1_extended;
        endcase
    end

    // ----------------------------------------
    // Sub-blocks
    // ----------------------------------------
    alu_add alu_add_i (
        .data_rs1_i  (data_rs1_shifted),
        .data_rs2_i  (data_rs2),
        .instr_type_i(instr_type),
        .result_o    (add_result)
    );

    alu_shift alu_shift_i (
        .data_rs1_i  (data_rs1_extended),
        .data_rs2_i  (data_rs2),
        .instr_type_i(instr_type),
        .result_o    (shift_result)
    );

    alu_cmp alu_cmp_i (
        .data_rs1_i  (data_rs1),
        .data_rs2_i  (data_rs2),
        .instr_type_i(instr_type),
        .result_o    (cmp_result)
    );

    alu_logic alu_logic_i (
        .data_rs1_i  (data_rs1),
        .data_rs2_i  (data_rs2),
        .instr_type_i(instr_type),
        .result_o    (logic_result)
    );

    // Decode lists are independent, so check they never overlap
    always_comb begin
        sel[0] = instr_type inside {ADD, SUB, ADDW, SUBW, ADDUW, SH1ADD, SH1ADDUW,
                                    SH2ADD, SH2ADDUW, SH3ADD, SH3ADDUW};
        sel[1] = instr_type inside {SLL, SLLW, SRL, SRLW, SRA, SRAW, SLLIUW,
                                    ROR, ROL, RORW, ROLW};
        sel[2] = instr_type inside {SLT, SLTU, MIN, MAX, MINU, MAXU};
        sel[3] = instr_type inside {AND_INST, OR_INST, XOR_INST, XNOR_INST, ORN, ANDN};
        assert ($onehot0(sel))
            else $error("alu: more than one sub-block selected");
    end

    assign result_modules = ({64{sel[0]}} & add_result)
                          | ({64{sel[1]}} & shift_result)
                          | ({64{sel[2]}} & cmp_result)
                          | ({64{sel[3]}} & logic_result);

    // ----------------------------------------
    // Result and metadata
    // ----------------------------------------
    always_comb begin
        case (instr_type)
            ADDW, SUBW, SLLW, SRLW, SRAW, RORW, ROLW: begin
                result = {{32{result_modules[31]}}, result_modules[31:0]};
            end
            ZEXTW, ZEXTH, SEXTH, SEXTB: begin
                result = data_rs1_extended;
            end
            default: begin
                if (|sel)
                    result = result_modules;
                else if (instruction_i.unit == UNIT_SYSTEM)
                    result = data_rs1;
                else
                    result = '0;
            end
        endcase
    end

    always_comb begin
        instruction_o.valid      = instruction_i.valid &
                                   ((instruction_i.unit == UNIT_ALU) |
                                    (instruction_i.unit == UNIT_SYSTEM));
        instruction_o.pc         = instruction_i.pc;
        instruction_o.rd         = instruction_i.rd;
        instruction_o.regfile_we = instruction_i.regfile_we;
        instruction_o.instr_type = instr_type;
        instruction_o.result     = result;
        instruction_o.tag        = instruction_i.tag;
    end

endmodule

`default_nettype wire

//--- rtl/alu_add.sv
// Adder and subtracter for the ALU
// Shift-add forms expect rs1 already shifted by the caller
// Word forms return the raw 64-bit sum; sign extension is done in the ALU
`timescale 1ns/1ps
`default_nettype none

module alu_add (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);
    import alu_pkg::*;

    logic   is_sub;
    bus64_t operand_b;

    // Subtract as add of the inverted operand plus one
    always_comb begin
        case (instr_type_i)
            SUB, SUBW: begin
                is_sub = 1'b1;
            end
            default: begin
                is_sub = 1'b0;
            end
        endcase
    end

    assign operand_b = data_rs2_i ^ {64{is_sub}};

    // Carry out is dropped, overflow wraps
    assign result_o = data_rs1_i + operand_b + {63'b0, is_sub};

endmodule

`default_nettype wire

//--- rtl/alu_cmp.sv
// Signed and unsigned compare for the ALU
// Covers SLT, SLTU and the min/max group; other types give zero
`timescale 1ns/1ps
`default_nettype none

module alu_cmp (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);
    import alu_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    // One compare of each kind, shared by every operation
    assign lt_signed   = $signed(data_rs1_i) < $signed(data_rs2_i);
    assign lt_unsigned = data_rs1_i < data_rs2_i;

    always_comb begin
        case (instr_type_i)
            SLT:     result_o = {63'b0, lt_signed};
            SLTU:    result_o = {63'b0, lt_unsigned};
            MIN:     result_o = lt_signed ? data_rs1_i : data_rs2_i;
            MAX:     result_o = lt_signed ? data_rs2_i : data_rs1_i;
            MINU:    result_o = lt_unsigned ? data_rs1_i : data_rs2_i;
            MAXU:    result_o = lt_unsigned ? data_rs2_i : data_rs1_i;
            default: result_o = '0;
        endcase

        // Set-less-than writes back a boolean, and the two compares
        // only disagree when the operand signs differ
        if (instr_type_i == SLT || instr_type_i == SLTU) begin
            assert (result_o[63:1] == '0 &&
                    (lt_signed ^ lt_unsigned) == (data_rs1_i[63] ^ data_rs2_i[63]))
                else $error("alu_cmp: set-less-than result is not a consistent 0 or 1");
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu_logic.sv
// Bitwise operations for the ALU
// ANDN and ORN take the inverted rs2; other types give zero
`timescale 1ns/1ps
`default_nettype none

module alu_logic (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);
    import alu_pkg::*;

    bus64_t rs2_inv;

    assign rs2_inv = ~data_rs2_i;

    always_comb begin
        case (instr_type_i)
            AND_INST:  result_o = data_rs1_i & data_rs2_i;
            OR_INST:   result_o = data_rs1_i | data_rs2_i;
            XOR_INST:  result_o = data_rs1_i ^ data_rs2_i;
            XNOR_INST: result_o = data_rs1_i ^ rs2_inv;
            ANDN:      result_o = data_rs1_i & rs2_inv;
            ORN:       result_o = data_rs1_i | rs2_inv;
            default:   result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/alu_pkg.sv
// Shared types for the integer ALU execute stage of an RV64 core
// Data width is fixed at 64 by the ISA; only the tag width is tunable here
// instr_type_t and unit_t widths are fixed at 6 and 2 bits
`default_nettype none

package alu_pkg;

    // ----------------------------------------
    // Basic words
    // ----------------------------------------
    localparam int TAG_WIDTH = 8;

    typedef logic [63:0] bus64_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // ----------------------------------------
    // Operation and unit encodings
    // ----------------------------------------
    // NOP sits at zero so an idle bus decodes as no operation
    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, ADDW, SUBW, ADDUW,
        SH1ADD, SH1ADDUW, SH2ADD, SH2ADDUW, SH3ADD, SH3ADDUW,
        SLL, SLLW, SRL, SRLW, SRA, SRAW, SLLIUW,
        ROR, ROL, RORW, ROLW,
        SLT, SLTU, MIN, MAX, MINU, MAXU,
        AND_INST, OR_INST, XOR_INST, XNOR_INST, ORN, ANDN,
        ZEXTW, ZEXTH, SEXTH, SEXTB
    } instr_type_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_SYSTEM,
        UNIT_OTHER
    } unit_t;

    // ----------------------------------------
    // Stage structs
    // ----------------------------------------
    // Read-register to execute
    typedef struct packed {
        logic        valid;
        unit_t       unit;
        instr_type_t instr_type;
        bus64_t      pc;
        logic [4:0]  rd;
        logic        regfile_we;
        bus64_t      data_rs1;
        bus64_t      data_rs2;
        tag_t        tag;
    } rr_exe_arith_instr_t;

    // Execute to write-back
    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        logic [4:0]  rd;
        logic        regfile_we;
        instr_type_t instr_type;
        bus64_t      result;
        tag_t        tag;
    } exe_wb_scalar_instr_t;

endpackage

`default_nettype wire

//--- rtl/alu_shift.sv
// Shifts and rotates for the ALU
// Word forms expect rs1 already zero- or sign-extended from bit 31
// Word results are only valid in the low 32 bits
`timescale 1ns/1ps
`default_nettype none

module alu_shift (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);
    import alu_pkg::*;

    logic [5:0]   shamt;
    logic [127:0] rot64_right;
    logic [127:0] rot64_left;
    logic [63:0]  rot32_right;
    logic [63:0]  rot32_left;

    // Word forms only look at five bits of rs2
    always_comb begin
        case (instr_type_i)
            SLLW, SRLW, SRAW, RORW, ROLW: begin
                shamt = {1'b0, data_rs2_i[4:0]};
            end
            default: begin
                shamt = data_rs2_i[5:0];
            end
        endcase
    end

    // Rotates built from a doubled word
    assign rot64_right = {data_rs1_i, data_rs1_i} >> shamt;
    assign rot64_left  = {data_rs1_i, data_rs1_i} << shamt;
    assign rot32_right = {data_rs1_i[31:0], data_rs1_i[31:0]} >> shamt;
    assign rot32_left  = {data_rs1_i[31:0], data_rs1_i[31:0]} << shamt;

    always_comb begin
        case (instr_type_i)
            SLL, SLLW, SLLIUW: begin
                result_o = data_rs1_i << shamt;
            end
            SRL, SRLW: begin
                result_o = data_rs1_i >> shamt;
            end
            SRA, SRAW: begin
                result_o = $signed(data_rs1_i) >>> shamt;
            end
            ROR: begin
                result_o = rot64_right[63:0];
            end
            ROL: begin
                result_o = rot64_left[127:64];
            end
            RORW: begin
                result_o = {32'b0, rot32_right[31:0]};
            end
            ROLW: begin
                result_o = {32'b0, rot32_left[63:32]};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/exe_alu_stage.sv
// Execute stage top: ALU plus one register towards write-back
// Latency is exactly one cycle, no back-pressure, new input every cycle
// Reset is synchronous and clears only the output valid
`timescale 1ns/1ps
`default_nettype none

module exe_alu_stage (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  alu_pkg::rr_exe_arith_instr_t  instruction_i,
    output alu_pkg::exe_wb_scalar_instr_t instruction_o
);
    import alu_pkg::*;

    exe_wb_scalar_instr_t alu_instr;
    exe_wb_scalar_instr_t payload_q;
    logic                 valid_q;

    alu alu_i (
        .instruction_i(instruction_i),
        .instruction_o(alu_instr)
    );

    // Control bit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= alu_instr.valid;
        end
    end

    // Payload, overwritten every cycle
    always_ff @(posedge clk_i) begin
        payload_q <= alu_instr;
    end

    always_comb begin
        instruction_o       = payload_q;
        instruction_o.valid = valid_q;
    end

    // Nothing leaves the stage in the cycle after a reset
    assert property (@(posedge clk_i) reset_i |=> !instruction_o.valid)
        else $error("exe_alu_stage: valid output right after reset");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_exe_alu_stage -f filelist.f \
    && ./obj_dir/Vtb_exe_alu_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

//--- test/alu_checker.sv
// Scoreboard for the ALU execute stage, samples on the falling clock edge
// Expects one cycle of latency and compares against an independent model
// Payload fields are only compared when the expected valid is high
`timescale 1ns/1ps
`default_nettype none

module alu_checker (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  alu_pkg::rr_exe_arith_instr_t  instruction_i,
    input  alu_pkg::exe_wb_scalar_instr_t instruction_o,
    output int                            error_count_o,
    output int                            check_count_o
);
    import alu_pkg::*;

    rr_exe_arith_instr_t  prev_in;
    exe_wb_scalar_instr_t expected;
    logic                 prev_reset;
    bit                   have_prev;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic bus64_t sext_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic exe_wb_scalar_instr_t ref_alu(input rr_exe_arith_instr_t in);
        exe_wb_scalar_instr_t exp;
        bus64_t               a;
        bus64_t               b;
        bus64_t               r;
        logic [31:0]          w;
        logic [5:0]           idx6;
        logic [4:0]           idx5;
        int                   i;
        a = in.data_rs1;
        b = in.data_rs2;
        r = '0;
        w = '0;
        case (in.instr_type)
            ADD:      r = a + b;
            SUB:      r = a - b;
            ADDW:     r = sext_word(a[31:0] + b[31:0]);
            SUBW:     r = sext_word(a[31:0] - b[31:0]);
            ADDUW:    r = {32'b0, a[31:0]} + b;
            SH1ADD:   r = (a << 1) + b;
            SH2ADD:   r = (a << 2) + b;
            SH3ADD:   r = (a << 3) + b;
            SH1ADDUW: r = ({32'b0, a[31:0]} << 1) + b;
            SH2ADDUW: r = ({32'b0, a[31:0]} << 2) + b;
            SH3ADDUW: r = ({32'b0, a[31:0]} << 3) + b;
            SLL:      r = a << b[5:0];
            SRL:      r = a >> b[5:0];
            SRA:      r = $signed(a) >>> b[5:0];
            SLLIUW:   r = {32'b0, a[31:0]} << b[5:0];
            SLLW: begin
                w = a[31:0] << b[4:0];
                r = sext_word(w);
            end
            SRLW: begin
                w = a[31:0] >> b[4:0];
                r = sext_word(w);
            end
            SRAW: begin
                w = $signed(a[31:0]) >>> b[4:0];
                r = sext_word(w);
            end
            // Rotates bit by bit, index wraps with its own width
            ROR, ROL: begin
                for (i = 0; i < 64; i++) begin
                    idx6 = 6'(i);
                    if (in.instr_type == ROR)
                        r[idx6] = a[idx6 + b[5:0]];
                    else
                        r[idx6] = a[idx6 - b[5:0]];
                end
            end
            RORW, ROLW: begin
                for (i = 0; i < 32; i++) begin
                    idx5 = 5'(i);
                    if (in.instr_type == RORW)
                        w[idx5] = a[idx5 + b[4:0]];
                    else
                        w[idx5] = a[idx5 - b[4:0]];
                end
                r = sext_word(w);
            end
            SLT:       r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU:      r = (a < b) ? 64'd1 : 64'd0;
            MIN:       r = ($signed(a) < $signed(b)) ? a : b;
            MAX:       r = ($signed(a) > $signed(b)) ? a : b;
            MINU:      r = (a < b) ? a : b;
            MAXU:      r = (a > b) ? a : b;
            AND_INST:  r = a & b;
            OR_INST:   r = a | b;
            XOR_INST:  r = a ^ b;
            XNOR_INST: r = ~(a ^ b);
            ORN:       r = a | ~b;
            ANDN:      r = a & ~b;
            ZEXTW:     r = {32'b0, a[31:0]};
            ZEXTH:     r = {48'b0, a[15:0]};
            SEXTH:     r = {{48{a[15]}}, a[15:0]};
            SEXTB:     r = {{56{a[7]}}, a[7:0]};
            default:   r = (in.unit == UNIT_SYSTEM) ? a : 64'd0;
        endcase
        exp.valid      = in.valid && (in.unit == UNIT_ALU || in.unit == UNIT_SYSTEM);
        exp.pc         = in.pc;
        exp.rd         = in.rd;
        exp.regfile_we = in.regfile_we;
        exp.instr_type = in.instr_type;
        exp.result     = r;
        exp.tag        = in.tag;
        return exp;
    endfunction

    // ----------------------------------------
    // Comparison
    // ----------------------------------------
    task automatic check_field(input string name, input bus64_t exp, input bus64_t act);
        check_count_o++;
        if (exp !== act) begin
            error_count_o++;
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Output at this falling edge belongs to the input seen one falling edge ago
    always @(negedge clk_i) begin
        if (have_prev) begin
            if (prev_reset) begin
                check_field("instruction_o.valid", 64'd0, 64'(instruction_o.valid));
            end else begin
                expected = ref_alu(prev_in);
                check_field("instruction_o.valid", 64'(expected.valid),
                            64'(instruction_o.valid));
                if (expected.valid) begin
                    check_field("instruction_o.pc", expected.pc, instruction_o.pc);
                    check_field("instruction_o.rd", 64'(expected.rd), 64'(instruction_o.rd));
                    check_field("instruction_o.regfile_we", 64'(expected.regfile_we),
                                64'(instruction_o.regfile_we));
                    check_field("instruction_o.instr_type", 64'(expected.instr_type),
                                64'(instruction_o.instr_type));
                    check_field("instruction_o.tag", 64'(expected.tag), 64'(instruction_o.tag));
                    check_field("instruction_o.result", expected.result, instruction_o.result);
                end
            end
        end
        prev_in    = instruction_i;
        prev_reset = reset_i;
        have_prev  = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_exe_alu_stage.sv
// Testbench for the ALU execute stage
// Inputs change 5 ns after each rising edge, the checker samples on falling edges
// Directed corners first, then random instructions from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_exe_alu_stage;
    import alu_pkg::*;

    localparam int NUM_TYPES      = 39;
    localparam int NUM_DIRECTED   = NUM_TYPES * 4 + 6 * 6 * 6 + 2;
    localparam int NUM_RANDOM     = 206;
    localparam int TIMEOUT_CYCLES = NUM_DIRECTED + NUM_RANDOM + 20;

    logic                 clk_i;
    logic                 reset_i;
    rr_exe_arith_instr_t  instruction_i;
    exe_wb_scalar_instr_t instruction_o;
    int                   error_count;
    int                   check_count;
    int                   cycle_count;
    int                   seed;
    tag_t                 next_tag;

    exe_alu_stage exe_alu_stage_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instruction_i(instruction_i),
        .instruction_o(instruction_o)
    );

    alu_checker alu_checker_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instruction_i(instruction_i),
        .instruction_o(instruction_o),
        .error_count_o(error_count),
        .check_count_o(check_count)
    );

    always #50 clk_i = ~clk_i;

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic bus64_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Sign boundaries and word boundaries
    function automatic bus64_t corner(input int idx);
        case (idx)
            0:       return 64'h0000_0000_0000_0000;
            1:       return 64'h0000_0000_0000_0001;
            2:       return 64'hffff_ffff_ffff_ffff;
            3:       return 64'h8000_0000_0000_0000;
            4:       return 64'h7fff_ffff_ffff_ffff;
            default: return 64'h0000_0000_8000_0000;
        endcase
    endfunction

    function automatic logic [5:0] shift_corner(input int idx);
        case (idx)
            0:       return 6'd0;
            1:       return 6'd31;
            2:       return 6'd32;
            default: return 6'd63;
        endcase
    endfunction

    function automatic unit_t pick_unit(input int r);
        case (r % 8)
            6:       return UNIT_SYSTEM;
            7:       return UNIT_OTHER;
            default: return UNIT_ALU;
        endcase
    endfunction

    // Apply one instruction and hold it for one clock
    task automatic drive_instr(input logic valid, input unit_t unit, input instr_type_t ty,
                               input bus64_t rs1, input bus64_t rs2);
        instruction_i.valid      = valid;
        instruction_i.unit       = unit;
        instruction_i.instr_type = ty;
        instruction_i.pc         = rand_word();
        instruction_i.rd         = 5'($random(seed));
        instruction_i.regfile_we = 1'($random(seed));
        instruction_i.data_rs1   = rs1;
        instruction_i.data_rs2   = rs2;
        instruction_i.tag        = next_tag;
        next_tag                 = next_tag + 1'b1;
        @(posedge clk_i);
        #5;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        bus64_t rs1;
        bus64_t rs2;
        int     t;
        int     j;
        int     k;
        seed     = 32'h8974880e;
        next_tag = '0;
        clk_i    = 1'b0;
        reset_i  = 1'b1;
        // A valid instruction during reset must not come out
        instruction_i            = '0;
        instruction_i.valid      = 1'b1;
        instruction_i.unit       = UNIT_ALU;
        instruction_i.instr_type = ADD;
        repeat (4) @(posedge clk_i);
        #5;
        reset_i = 1'b0;

        // Every type against the shift amount corners, upper rs2 bits random
        for (t = 0; t < NUM_TYPES; t++) begin
            for (k = 0; k < 4; k++) begin
                rs2      = rand_word();
                rs2[5:0] = shift_corner(k);
                drive_instr(1'b1, UNIT_ALU, instr_type_t'(6'(t)), corner((t + k) % 6), rs2);
            end
        end

        // Compare group on all pairs of boundary operands
        for (t = 0; t < 6; t++) begin
            for (j = 0; j < 6; j++) begin
                for (k = 0; k < 6; k++) begin
                    drive_instr(1'b1, UNIT_ALU, instr_type_t'(6'(SLT + t)), corner(j), corner(k));
                end
            end
        end

        drive_instr(1'b1, UNIT_SYSTEM, NOP, rand_word(), rand_word());
        drive_instr(1'b1, UNIT_OTHER, ADD, rand_word(), rand_word());

        for (j = 0; j < NUM_RANDOM; j++) begin
            rs1 = rand_word();
            rs2 = rand_word();
            if (($random(seed) & 3) == 0)
                rs1 = corner($unsigned($random(seed)) % 6);
            drive_instr(($random(seed) & 7) != 0, pick_unit($unsigned($random(seed)) % 8),
                        instr_type_t'(6'($unsigned($random(seed)) % NUM_TYPES)), rs1, rs2);
        end

        // Let the last instruction drain through the checker
        drive_instr(1'b0, UNIT_ALU, NOP, '0, '0);
        drive_instr(1'b0, UNIT_ALU, NOP, '0, '0);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire
